//--- tb.f
source/videoPkg.sv
source/videoSyncGen.sv
source/pixelPatternGen.sv
source/channelBlendLane.sv
source/tftOutputStage.sv
source/backlightPwm.sv
source/videoTxTop.sv
verification/videoTx_chk.sv
verification/videoTxTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the video transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=build
simLog=sim.log

# Compile the file list into one simulation binary
verilator --binary --timing --assert --top-module videoTxTb \
	-f tb.f -Mdir "$buildDir" -o videoTxSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# Run and keep the transcript
"./$buildDir/videoTxSim" > "$simLog" 2>&1
runStatus=$?
cat "$simLog"
if [ $runStatus -ne 0 ]; then
	echo "simulation stopped with status $runStatus"
	exit 1
fi

# Verdict is a line of its own in the transcript
if grep -qx "Testbench passed" "$simLog"; then
	exit 0
fi
echo "no pass line in $simLog"
exit 1

//--- verification/videoTxTb.sv
// TFT video transmitter testbench
`timescale 1ns/1ps
`default_nettype none

module videoTxTb;

	// ----------------------------------------------------------
	// Small video timing
	// ----------------------------------------------------------

	localparam int lHActive = 32;
	localparam int lHPorch = 4;
	localparam int lVActive = 6;
	localparam int lVPorch = 1;
	localparam int lBarShift = 2;
	// Porch, sync and porch, all the same size
	localparam int lLineClocks = lHActive + 3 * lHPorch;
	localparam int lFrameClocks = lLineClocks * (lVActive + 3 * lVPorch);
	localparam int lWaitLimit = 2 * lFrameClocks;
	localparam int lSettleClocks = 4;
	// Pin selectors for edge waits
	localparam int lSelHSync = 0;
	localparam int lSelDe = 1;
	localparam int lSelFe = 2;

	logic        iVideoClk;
	logic        rstN;
	logic        iPatternSel;
	logic [11:0] iBgColor;
	logic [7:0]  iBlDuty;
	logic [3:0]  oTftColorR;
	logic [3:0]  oTftColorG;
	logic [3:0]  oTftColorB;
	logic        oHSync;
	logic        oVSync;
	logic        oDe;
	logic        oFrameEnd;
	logic        oBackLight;

	// Pin monitor state
	int          pixCount;
	bit          prevVSync;
	int          pixelsChecked;
	int          blankClocks;
	int          monitorErrors;
	// Sequence state
	logic        checkEn;
	logic        refMode;
	logic [11:0] refBg;
	string       curTest;
	int          mainErrors;
	logic        timedOut;
	int          testStartErrors;
	int          testsRun;
	int          testsFailed;
	logic [31:0] rngState;

	videoTxTop #(
		.pHActive  (lHActive),
		.pHFront   (lHPorch),
		.pHSync    (lHPorch),
		.pHBack    (lHPorch),
		.pVActive  (lVActive),
		.pVFront   (lVPorch),
		.pVSync    (lVPorch),
		.pVBack    (lVPorch),
		.pBarShift (lBarShift)
	) dut_i (
		.iVideoClk   (iVideoClk),
		.rstN        (rstN),
		.iPatternSel (iPatternSel),
		.iBgColor    (iBgColor),
		.iBlDuty     (iBlDuty),
		.oTftColorR  (oTftColorR),
		.oTftColorG  (oTftColorG),
		.oTftColorB  (oTftColorB),
		.oHSync      (oHSync),
		.oVSync      (oVSync),
		.oDe         (oDe),
		.oFrameEnd   (oFrameEnd),
		.oBackLight  (oBackLight)
	);

	initial
	begin
		iVideoClk = 1'b0;
		forever #2 iVideoClk = ~iVideoClk;
	end

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Weights alpha+1 and 15-alpha, then divide by 16
	function automatic int blendComponent(input int c, input int a, input int bg);
		return (c * (a + 1) + bg * (15 - a)) >> 4;
	endfunction

	// Expected R G B at the pins for one position
	function automatic logic [11:0] refPixel(input int x, input int y, input logic mode,
		input logic [11:0] bg);
		int bar;
		int r;
		int g;
		int b;
		int a;
		bar = x >> lBarShift;
		if (mode)
		begin
			r = x % 16;
			g = y % 16;
			b = (x ^ y) % 16;
			a = (x / 2) % 16;
		end
		else
		begin
			// Bar bits 2 1 0 pick red green blue
			r = ((bar / 4) % 2) * 15;
			g = ((bar / 2) % 2) * 15;
			b = (bar % 2) * 15;
			a = 15;
		end
		return {4'(blendComponent(r, a, int'(bg[11:8]))),
			4'(blendComponent(g, a, int'(bg[7:4]))),
			4'(blendComponent(b, a, int'(bg[3:0])))};
	endfunction

	// ----------------------------------------------------------
	// Pin monitor and pixel compare
	// ----------------------------------------------------------

	// Mid-cycle sampling, pins settle on the rising edge
	always @(negedge iVideoClk)
	begin : pinMonitor
		logic [11:0] pinColor;
		logic [11:0] expColor;
		pinColor = {oTftColorR, oTftColorG, oTftColorB};
		if (!rstN)
		begin
			pixCount = 0;
			prevVSync = 1'b0;
		end
		else
		begin
			// New frame count starts at VSync rise
			if (oVSync && !prevVSync)
				pixCount = 0;
			prevVSync = oVSync;
			if (oDe)
			begin
				if (checkEn)
				begin
					expColor = refPixel(pixCount % lHActive, pixCount / lHActive, refMode, refBg);
					if (pinColor !== expColor)
					begin
						$display("error %s pixel x=%0d y=%0d expected 0x%03h actual 0x%03h",
							curTest, pixCount % lHActive, pixCount / lHActive, expColor, pinColor);
						monitorErrors++;
					end
					pixelsChecked++;
				end
				pixCount++;
			end
			else
			begin
				blankClocks++;
				if (pinColor !== 12'h000)
				begin
					$display("error %s blanking expected 0x000 actual 0x%03h", curTest, pinColor);
					monitorErrors++;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Sequence helpers
	// ----------------------------------------------------------

	// Rising edge plus drive delay
	task automatic tick();
		@(posedge iVideoClk);
		#1;
	endtask

	function automatic logic pinLevel(input int sel);
		case (sel)
			lSelHSync: return oHSync;
			lSelDe:    return oDe;
			default:   return oFrameEnd;
		endcase
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("error %s %s expected %0d actual %0d", curTest, what, expected, actual);
			mainErrors++;
		end
	endtask

	// Clocks until the selected pin rises, bounded
	task automatic waitRise(input int sel, input string what, output int clocks);
		logic prev;
		clocks = 0;
		if (timedOut)
			return;
		while (clocks < lWaitLimit)
		begin
			prev = pinLevel(sel);
			tick();
			clocks++;
			if (pinLevel(sel) && !prev)
				return;
		end
		$display("%s: %s did not rise within %0d clocks", curTest, what, lWaitLimit);
		mainErrors++;
		timedOut = 1'b1;
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testStartErrors = mainErrors + monitorErrors;
	endtask

	task automatic finishTest();
		int n;
		n = mainErrors + monitorErrors - testStartErrors;
		testsRun++;
		if (n == 0)
			$display("test %s: ok", curTest);
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", curTest, n);
		end
	endtask

	task automatic checkPinsIdle();
		checkValue("oHSync", 0, int'(oHSync));
		checkValue("oVSync", 0, int'(oVSync));
		checkValue("oDe", 0, int'(oDe));
		checkValue("oFrameEnd", 0, int'(oFrameEnd));
		checkValue("oBackLight", 0, int'(oBackLight));
		checkValue("colour", 0, int'({oTftColorR, oTftColorG, oTftColorB}));
	endtask

	// Inputs change in vertical blank, next frame is compared
	task automatic checkFrame(input logic mode, input logic [11:0] bg);
		int startPixels;
		int clocks;
		waitRise(lSelFe, "oFrameEnd", clocks);
		tick();
		iPatternSel = mode;
		iBgColor = bg;
		refMode = mode;
		refBg = bg;
		startPixels = pixelsChecked;
		checkEn = 1'b1;
		waitRise(lSelFe, "oFrameEnd", clocks);
		// Last pixel is compared on this cycle's falling edge
		tick();
		checkEn = 1'b0;
		checkValue("pixels checked", lHActive * lVActive, pixelsChecked - startPixels);
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------

	initial
	begin
		logic [7:0] duty;
		logic       deBefore;
		int         clocks;
		int         runLen;
		int         lines;
		int         startBlank;
		int         highClocks;
		int         k;
		rstN = 1'b0;
		iPatternSel = 1'b0;
		iBgColor = 12'h000;
		iBlDuty = 8'h00;
		checkEn = 1'b0;
		refMode = 1'b0;
		refBg = 12'h000;
		timedOut = 1'b0;
		rngState = 32'h85ce;
		curTest = "idle";

		// Pins idle in reset and while the pipeline fills
		startTest("reset");
		repeat (2)
		begin
			tick();
			checkPinsIdle();
		end
		rstN = 1'b1;
		repeat (2)
		begin
			tick();
			checkPinsIdle();
		end
		finishTest();

		startTest("timing");
		waitRise(lSelHSync, "oHSync", clocks);
		waitRise(lSelHSync, "oHSync", clocks);
		checkValue("clocks per line", lLineClocks, clocks);
		waitRise(lSelDe, "oDe", clocks);
		runLen = 0;
		while (oDe && runLen < lWaitLimit)
		begin
			runLen++;
			tick();
		end
		checkValue("DE clocks per line", lHActive, runLen);
		waitRise(lSelFe, "oFrameEnd", clocks);
		// DE rises up to the next frame end
		lines = 0;
		clocks = 0;
		do
		begin
			deBefore = oDe;
			tick();
			clocks++;
			if (oDe && !deBefore)
				lines++;
		end
		while (!oFrameEnd && clocks < lWaitLimit);
		checkValue("active lines per frame", lVActive, lines);
		checkValue("clocks per frame", lFrameClocks, clocks);
		finishTest();

		// Opaque bars hide the background
		startTest("colour bars");
		rngState = xorshift(rngState);
		checkFrame(1'b0, rngState[11:0]);
		finishTest();

		startTest("gradient");
		repeat (3)
		begin
			rngState = xorshift(rngState);
			checkFrame(1'b1, rngState[11:0]);
		end
		finishTest();

		// Monitor flags colour outside DE on every clock
		startTest("blanking");
		waitRise(lSelFe, "oFrameEnd", clocks);
		startBlank = blankClocks;
		waitRise(lSelFe, "oFrameEnd", clocks);
		checkValue("blank clocks per frame", lFrameClocks - lHActive * lVActive,
			blankClocks - startBlank);
		finishTest();

		// Full PWM period after settling, both extremes first
		startTest("backlight");
		for (k = 0; k < 6; k++)
		begin
			rngState = xorshift(rngState);
			if (k == 0)
				duty = 8'h00;
			else if (k == 1)
				duty = 8'hff;
			else
				duty = rngState[7:0];
			iBlDuty = duty;
			repeat (lSettleClocks) tick();
			highClocks = 0;
			repeat (256)
			begin
				tick();
				if (oBackLight)
					highClocks++;
			end
			checkValue($sformatf("high clocks at duty %0d", duty), int'(duty), highClocks);
		end
		finishTest();

		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed,
			mainErrors + monitorErrors);
		if (testsFailed == 0 && mainErrors + monitorErrors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/videoTx_chk.sv
// TFT pin protocol assertions
`timescale 1ns/1ps
`default_nettype none

module videoTxChk (
	input wire logic                              iVideoClk,
	input wire logic                              rstN,
	input wire logic [videoPkg::cColorBits-1:0]   tftColorR,
	input wire logic [videoPkg::cColorBits-1:0]   tftColorG,
	input wire logic [videoPkg::cColorBits-1:0]   tftColorB,
	input wire logic                              hSync,
	input wire logic                              de,
	input wire logic                              frameEnd
);

	// ----------------------------------------------------------
	// Pin rules
	// ----------------------------------------------------------

	// Colour blanked outside active video
	blankOutsideDe: assert property (
		@(posedge iVideoClk) disable iff (!rstN)
		!de |-> (tftColorR == '0 && tftColorG == '0 && tftColorB == '0)
	)
	else
		$error("colour pins not zero while DE is low");

	// Sync pulse sits in the horizontal blank
	noDeInHSync: assert property (
		@(posedge iVideoClk) disable iff (!rstN)
		hSync |-> !de
	)
	else
		$error("DE high during HSync");

	// Frame end is a single clock strobe
	frameEndSingle: assert property (
		@(posedge iVideoClk) disable iff (!rstN)
		frameEnd |=> !frameEnd
	)
	else
		$error("frame end held longer than one clock");

	// Marks an active pixel
	frameEndInDe: assert property (
		@(posedge iVideoClk) disable iff (!rstN)
		frameEnd |-> de
	)
	else
		$error("frame end outside active video");

endmodule

// Attach to the transmitter top
bind videoTxTop videoTxChk chk_i (
	.iVideoClk (iVideoClk),
	.rstN      (rstN),
	.tftColorR (oTftColorR),
	.tftColorG (oTftColorG),
	.tftColorB (oTftColorB),
	.hSync     (oHSync),
	.de        (oDe),
	.frameEnd  (oFrameEnd)
);

`default_nettype wire

//--- source/videoTxTop.sv
// TFT video transmitter top
`timescale 1ns/1ps
`default_nettype none

module videoTxTop #(
	parameter int pHActive  = 480,
	parameter int pHFront   = 2,
	parameter int pHSync    = 41,
	parameter int pHBack    = 2,
	parameter int pVActive  = 272,
	parameter int pVFront   = 2,
	parameter int pVSync    = 10,
	parameter int pVBack    = 2,
	// Bar width as a power of two
	parameter int pBarShift = 6
)(
	input  wire logic                                             iVideoClk,
	input  wire logic                                             rstN,
	input  wire logic                                             iPatternSel,
	// Background R G B, red in the top nibble
	input  wire logic [videoPkg::cLanes*videoPkg::cColorBits-1:0] iBgColor,
	input  wire logic [7:0]                                       iBlDuty,
	output logic [videoPkg::cColorBits-1:0]                       oTftColorR,
	output logic [videoPkg::cColorBits-1:0]                       oTftColorG,
	output logic [videoPkg::cColorBits-1:0]                       oTftColorB,
	output logic                                                  oHSync,
	output logic                                                  oVSync,
	output logic                                                  oDe,
	output logic                                                  oFrameEnd,
	output logic                                                  oBackLight
);

	import videoPkg::*;

	// Timing generator outputs
	logic                syncHSync;
	logic                syncVSync;
	logic                syncDe;
	logic                syncFe;
	logic [cPosBits-1:0] posX;
	logic [cPosBits-1:0] posY;

	// Pattern stage outputs
	logic [cLanes-1:0][cColorBits-1:0] color;
	logic [cColorBits-1:0]             alpha;
	logic                              patHSync;
	logic                              patVSync;
	logic                              patDe;
	logic                              patFe;

	// Blended lanes
	logic [cLanes-1:0][cColorBits-1:0] laneColor;

	// ----------------------------------------------------------
	// Timing and pattern
	// ----------------------------------------------------------

	videoSyncGen #(
		.pHActive (pHActive),
		.pHFront  (pHFront),
		.pHSync   (pHSync),
		.pHBack   (pHBack),
		.pVActive (pVActive),
		.pVFront  (pVFront),
		.pVSync   (pVSync),
		.pVBack   (pVBack)
	) syncGen_i (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.hSync     (syncHSync),
		.vSync     (syncVSync),
		.de        (syncDe),
		.fe        (syncFe),
		.posX      (posX),
		.posY      (posY)
	);

	pixelPatternGen #(
		.pBarShift (pBarShift)
	) patternGen_i (
		.iVideoClk   (iVideoClk),
		.rstN        (rstN),
		.hSync       (syncHSync),
		.vSync       (syncVSync),
		.de          (syncDe),
		.fe          (syncFe),
		.posX        (posX),
		.posY        (posY),
		.iPatternSel (iPatternSel),
		.color       (color),
		.alpha       (alpha),
		.patHSync    (patHSync),
		.patVSync    (patVSync),
		.patDe       (patDe),
		.patFe       (patFe)
	);

	// ----------------------------------------------------------
	// Colour lanes
	// ----------------------------------------------------------

	// Lane index matches the nibble position in iBgColor
	for (genvar gLane = 0; gLane < cLanes; gLane++)
	begin : genLane
		channelBlendLane lane_i (
			.iVideoClk (iVideoClk),
			.rstN      (rstN),
			.color     (color[gLane]),
			.alpha     (alpha),
			.bg        (iBgColor[gLane*cColorBits +: cColorBits]),
			.blended   (laneColor[gLane])
		);
	end

	// ----------------------------------------------------------
	// Pins and backlight
	// ----------------------------------------------------------

	tftOutputStage outStage_i (
		.iVideoClk  (iVideoClk),
		.rstN       (rstN),
		.laneColor  (laneColor),
		.patHSync   (patHSync),
		.patVSync   (patVSync),
		.patDe      (patDe),
		.patFe      (patFe),
		.oTftColorR (oTftColorR),
		.oTftColorG (oTftColorG),
		.oTftColorB (oTftColorB),
		.oHSync     (oHSync),
		.oVSync     (oVSync),
		.oDe        (oDe),
		.oFrameEnd  (oFrameEnd)
	);

	backlightPwm blPwm_i (
		.iVideoClk  (iVideoClk),
		.rstN       (rstN),
		.iBlDuty    (iBlDuty),
		.oBackLight (oBackLight)
	);

endmodule

`default_nettype wire

//--- source/backlightPwm.sv
// Backlight PWM dimmer
`timescale 1ns/1ps
`default_nettype none

module backlightPwm (
	input  wire logic       iVideoClk,
	input  wire logic       rstN,
	input  wire logic [7:0] iBlDuty,
	output logic            oBackLight
);

	// Free-running period counter, wraps every 256 clocks
	logic [7:0] pwmCnt;

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwmCnt     <= '0;
			oBackLight <= 1'b0;
		end
		else
		begin
			pwmCnt <= pwmCnt + 8'd1;
			// High for iBlDuty counts out of every 256
			oBackLight <= (pwmCnt < iBlDuty);
		end
	end

endmodule

`default_nettype wire

//--- source/tftOutputStage.sv
// TFT pin output stage
`timescale 1ns/1ps
`default_nettype none

module tftOutputStage (
	input  wire logic                                                  iVideoClk,
	input  wire logic                                                  rstN,
	input  wire logic [videoPkg::cLanes-1:0][videoPkg::cColorBits-1:0] laneColor,
	input  wire logic                                                  patHSync,
	input  wire logic                                                  patVSync,
	input  wire logic                                                  patDe,
	input  wire logic                                                  patFe,
	output logic [videoPkg::cColorBits-1:0]                            oTftColorR,
	output logic [videoPkg::cColorBits-1:0]                            oTftColorG,
	output logic [videoPkg::cColorBits-1:0]                            oTftColorB,
	output logic                                                       oHSync,
	output logic                                                       oVSync,
	output logic                                                       oDe,
	output logic                                                       oFrameEnd
);

	import videoPkg::*;

	// Bundle order HSync VSync DE FE
	localparam int lSyncBits = 4;

	logic [cLaneLatency-1:0][lSyncBits-1:0] syncPipe;
	logic [lSyncBits-1:0]                   syncAligned;

	// ----------------------------------------------------------
	// Sync delay matching the lanes
	// ----------------------------------------------------------

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
			syncPipe <= '0;
		else
		begin
			syncPipe[0] <= {patHSync, patVSync, patDe, patFe};
			// Further stages only when lanes get deeper
			for (int i = 1; i < cLaneLatency; i++)
				syncPipe[i] <= syncPipe[i-1];
		end
	end

	assign syncAligned = syncPipe[cLaneLatency-1];

	// ----------------------------------------------------------
	// Pin registers
	// ----------------------------------------------------------

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			{oTftColorR, oTftColorG, oTftColorB} <= '0;
			{oHSync, oVSync, oDe, oFrameEnd} <= '0;
		end
		else
		begin
			// Blank colour outside active video
			if (syncAligned[1])
				{oTftColorR, oTftColorG, oTftColorB} <= laneColor;
			else
				{oTftColorR, oTftColorG, oTftColorB} <= '0;
			{oHSync, oVSync, oDe, oFrameEnd} <= syncAligned;
		end
	end

endmodule

`default_nettype wire

//--- source/channelBlendLane.sv
// Alpha blend colour lane
`timescale 1ns/1ps
`default_nettype none

module channelBlendLane (
	input  wire logic                              iVideoClk,
	input  wire logic                              rstN,
	input  wire logic [videoPkg::cColorBits-1:0]   color,
	input  wire logic [videoPkg::cColorBits-1:0]   alpha,
	input  wire logic [videoPkg::cColorBits-1:0]   bg,
	output logic [videoPkg::cColorBits-1:0]        blended
);

	import videoPkg::*;

	// Weights always sum to full scale so the sum fits this width
	localparam int lMixBits = 2 * cColorBits;
	localparam int lFullScale = (1 << cColorBits) - 1;

	logic [cColorBits-1:0] bgQ;
	logic [lMixBits-1:0]   fgWeight;
	logic [lMixBits-1:0]   bgWeight;
	logic [lMixBits-1:0]   mix;

	// ----------------------------------------------------------
	// Background capture
	// ----------------------------------------------------------

	// Background taken in step with the pattern stage
	always_ff @(posedge iVideoClk)
	begin
		bgQ <= bg;
	end

	// ----------------------------------------------------------
	// Blend
	// ----------------------------------------------------------

	// Foreground weight alpha+1, background the rest
	assign fgWeight = lMixBits'(alpha) + lMixBits'(1);
	assign bgWeight = lMixBits'(lFullScale) - lMixBits'(alpha);
	assign mix = lMixBits'(color) * fgWeight + lMixBits'(bgQ) * bgWeight;

	// Divide by 16 and register
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
			blended <= '0;
		else
			blended <= mix[lMixBits-1 -: cColorBits];
	end

endmodule

`default_nettype wire

//--- source/pixelPatternGen.sv
// ARGB4444 test pattern source
`timescale 1ns/1ps
`default_nettype none

module pixelPatternGen #(
	parameter int pBarShift = 6
)(
	input  wire logic                                              iVideoClk,
	input  wire logic                                              rstN,
	input  wire logic                                              hSync,
	input  wire logic                                              vSync,
	input  wire logic                                              de,
	input  wire logic                                              fe,
	input  wire logic [videoPkg::cPosBits-1:0]                     posX,
	input  wire logic [videoPkg::cPosBits-1:0]                     posY,
	input  wire logic                                              iPatternSel,
	output logic [videoPkg::cLanes-1:0][videoPkg::cColorBits-1:0]  color,
	output logic [videoPkg::cColorBits-1:0]                        alpha,
	output logic                                                   patHSync,
	output logic                                                   patVSync,
	output logic                                                   patDe,
	output logic                                                   patFe
);

	import videoPkg::*;

	logic [cPosBits-1:0]   bar;
	logic [cColorBits-1:0] redNext;
	logic [cColorBits-1:0] greenNext;
	logic [cColorBits-1:0] blueNext;
	logic [cColorBits-1:0] alphaNext;
	logic [cPixelBits-1:0] pixelNext;
	logic [cPixelBits-1:0] pixelQ;

	// ----------------------------------------------------------
	// Pattern decode
	// ----------------------------------------------------------

	// Bar index along the line
	assign bar = posX >> pBarShift;

	always_comb
	begin
		if (iPatternSel)
		begin
			// Gradient, alpha ramps every other pixel
			redNext   = posX[cColorBits-1:0];
			greenNext = posY[cColorBits-1:0];
			blueNext  = posX[cColorBits-1:0] ^ posY[cColorBits-1:0];
			alphaNext = posX[cColorBits:1];
		end
		else
		begin
			// Colour bars, fully opaque
			redNext   = {cColorBits{bar[2]}};
			greenNext = {cColorBits{bar[1]}};
			blueNext  = {cColorBits{bar[0]}};
			alphaNext = '1;
		end
	end

	// Alpha in the top nibble, then R G B
	assign pixelNext = {alphaNext, redNext, greenNext, blueNext};

	// ----------------------------------------------------------
	// Pixel and timing register
	// ----------------------------------------------------------

	always_ff @(posedge iVideoClk)
	begin
		pixelQ <= pixelNext;
	end

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			patHSync <= 1'b0;
			patVSync <= 1'b0;
			patDe    <= 1'b0;
			patFe    <= 1'b0;
		end
		else
		begin
			patHSync <= hSync;
			patVSync <= vSync;
			patDe    <= de;
			patFe    <= fe;
		end
	end

	// Split the word back into lanes and alpha
	assign alpha = pixelQ[cPixelBits-1 -: cColorBits];
	assign color = pixelQ[cLanes*cColorBits-1:0];

endmodule

`default_nettype wire

//--- source/videoSyncGen.sv
// Video timing generator
`timescale 1ns/1ps
`default_nettype none

module videoSyncGen #(
	parameter int pHActive = 480,
	parameter int pHFront  = 2,
	parameter int pHSync   = 41,
	parameter int pHBack   = 2,
	parameter int pVActive = 272,
	parameter int pVFront  = 2,
	parameter int pVSync   = 10,
	parameter int pVBack   = 2
)(
	input  wire logic                          iVideoClk,
	input  wire logic                          rstN,
	output logic                               hSync,
	output logic                               vSync,
	output logic                               de,
	output logic                               fe,
	output logic [videoPkg::cPosBits-1:0]      posX,
	output logic [videoPkg::cPosBits-1:0]      posY
);

	import videoPkg::*;

	// ----------------------------------------------------------
	// Interval boundaries
	// ----------------------------------------------------------

	// Last count of a line and of a frame
	localparam logic [cPosBits-1:0] lHLast =
		cPosBits'(pHActive + pHFront + pHSync + pHBack - 1);
	localparam logic [cPosBits-1:0] lVLast =
		cPosBits'(pVActive + pVFront + pVSync + pVBack - 1);
	// Active area ends
	localparam logic [cPosBits-1:0] lHActive = cPosBits'(pHActive);
	localparam logic [cPosBits-1:0] lVActive = cPosBits'(pVActive);
	localparam logic [cPosBits-1:0] lHActLast = cPosBits'(pHActive - 1);
	localparam logic [cPosBits-1:0] lVActLast = cPosBits'(pVActive - 1);
	// Sync windows, start inclusive and end exclusive
	localparam logic [cPosBits-1:0] lHSyncStart = cPosBits'(pHActive + pHFront);
	localparam logic [cPosBits-1:0] lHSyncEnd = cPosBits'(pHActive + pHFront + pHSync);
	localparam logic [cPosBits-1:0] lVSyncStart = cPosBits'(pVActive + pVFront);
	localparam logic [cPosBits-1:0] lVSyncEnd = cPosBits'(pVActive + pVFront + pVSync);

	logic [cPosBits-1:0] hCnt;
	logic [cPosBits-1:0] vCnt;
	logic [cPosBits-1:0] hNext;
	logic [cPosBits-1:0] vNext;
	logic                lineEnd;

	// ----------------------------------------------------------
	// Next counter state
	// ----------------------------------------------------------

	assign lineEnd = (hCnt == lHLast);
	assign hNext = lineEnd ? '0 : hCnt + cPosBits'(1);
	// Line count moves only on the last pixel of a line
	assign vNext = !lineEnd ? vCnt : ((vCnt == lVLast) ? '0 : vCnt + cPosBits'(1));

	// ----------------------------------------------------------
	// Counters with flags decoded from next state
	// ----------------------------------------------------------

	// Flags are decoded from the next count so that they stay in step
	// with the counter registers
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			// Park on the last blank pixel, every flag low there
			hCnt  <= lHLast;
			vCnt  <= lVLast;
			hSync <= 1'b0;
			vSync <= 1'b0;
			de    <= 1'b0;
			fe    <= 1'b0;
		end
		else
		begin
			hCnt  <= hNext;
			vCnt  <= vNext;
			hSync <= (hNext >= lHSyncStart) && (hNext < lHSyncEnd);
			vSync <= (vNext >= lVSyncStart) && (vNext < lVSyncEnd);
			de    <= (hNext < lHActive) && (vNext < lVActive);
			// Last active pixel of the frame
			fe    <= (hNext == lHActLast) && (vNext == lVActLast);
		end
	end

	// Position of the current pixel
	assign posX = hCnt;
	assign posY = vCnt;

endmodule

`default_nettype wire

//--- source/videoPkg.sv
// Video transmitter shared constants
`default_nettype none

package videoPkg;

	// ----------------------------------------------------------
	// Pixel format ARGB4444
	// ----------------------------------------------------------

	// One colour or alpha component
	localparam int cColorBits = 4;

	// Colour lanes, packed red green blue
	localparam int cLanes = 3;

	// Whole ARGB word
	localparam int cPixelBits = 16;

	// ----------------------------------------------------------
	// Pipeline and counters
	// ----------------------------------------------------------

	// Register stages inside one colour lane
	// Output stage delays sync by the same amount
	localparam int cLaneLatency = 1;

	// Pixel and line counter width
	localparam int cPosBits = 11;

endpackage

`default_nettype wire
